//--- include/spi_consts.svh
`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// character and field widths
`define SPI_MAX_CHAR       32  // widest character in bits
`define SPI_CHAR_LEN_BITS  5   // length field, zero means 32
`define SPI_DIV_LEN        16  // clock divider width

// word offsets on the 2-bit register address
`define SPI_ADDR_DATA  2'd0  // tx word on write, rx word on read
`define SPI_ADDR_CTRL  2'd1
`define SPI_ADDR_DIV   2'd2
`define SPI_ADDR_STAT  2'd3  // read clears done and irq

// control register bit positions, length sits in 4:0
`define SPI_CTRL_GO     8
`define SPI_CTRL_RXNEG  9   // sample miso on falling sclk
`define SPI_CTRL_TXNEG  10  // drive mosi on falling sclk
`define SPI_CTRL_LSB    11  // lsb first on the line
`define SPI_CTRL_IE     12  // interrupt enable

// status register bit positions
`define SPI_STAT_DONE  0
`define SPI_STAT_IRQ   1
`define SPI_STAT_TIP   2

`endif

//--- hw/spi_pkg.sv
`include "spi_consts.svh"

package spi_pkg;

  // one transfer word, written per byte lane and shifted per bit
  typedef union packed {
    logic [`SPI_MAX_CHAR-1:0]       word;
    logic [`SPI_MAX_CHAR/8-1:0][7:0] bytes;
  } spi_word_u;

endpackage

//--- hw/spi_reg_decode.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_reg_decode (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          wr_i,
  input  logic                          rd_i,
  input  logic [1:0]                    addr_i,
  input  logic [31:0]                   wdata_i,
  input  logic [3:0]                    be_i,
  input  logic                          tip_i,
  input  spi_pkg::spi_word_u            rx_word_i,
  input  logic                          done_i,
  input  logic                          irq_i,
  output logic [31:0]                   rdata_o,
  output logic                          latch_o,
  output logic [3:0]                    byte_sel_o,
  output spi_pkg::spi_word_u            tx_word_o,
  output logic [`SPI_CHAR_LEN_BITS-1:0] len_o,
  output logic                          lsb_o,
  output logic                          go_o,
  output logic                          rx_negedge_o,
  output logic                          tx_negedge_o,
  output logic                          ie_o,
  output logic [`SPI_DIV_LEN-1:0]       divider_o,
  output logic                          stat_rd_o
);

  logic        ctrl_wr;
  logic        div_wr;
  logic        tip_q;     // tip one cycle ago
  logic        tip_fall;
  logic        go_q;
  logic [31:0] ctrl_rd;

  assign ctrl_wr  = wr_i && (addr_i == `SPI_ADDR_CTRL) && !tip_i;
  assign div_wr   = wr_i && (addr_i == `SPI_ADDR_DIV) && !tip_i;
  assign tip_fall = tip_q && !tip_i;

  // data writes pass straight on, the shift block decides to merge
  assign latch_o         = wr_i && (addr_i == `SPI_ADDR_DATA);
  assign byte_sel_o      = be_i;
  assign tx_word_o.word  = wdata_i;
  assign stat_rd_o       = rd_i && (addr_i == `SPI_ADDR_STAT);

  // go drops in the first idle cycle so the shifter cannot restart
  assign go_o = go_q && !tip_fall;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      tip_q        <= 1'b0;
      go_q         <= 1'b0;
      len_o        <= '0;
      lsb_o        <= 1'b0;
      rx_negedge_o <= 1'b0;
      tx_negedge_o <= 1'b0;
      ie_o         <= 1'b0;
      divider_o    <= '0;
    end
    else
    begin
      tip_q <= tip_i;
      if (ctrl_wr)
      begin
        len_o        <= wdata_i[`SPI_CHAR_LEN_BITS-1:0];
        go_q         <= wdata_i[`SPI_CTRL_GO];
        rx_negedge_o <= wdata_i[`SPI_CTRL_RXNEG];
        tx_negedge_o <= wdata_i[`SPI_CTRL_TXNEG];
        lsb_o        <= wdata_i[`SPI_CTRL_LSB];
        ie_o         <= wdata_i[`SPI_CTRL_IE];
      end
      else if (tip_fall)
        go_q <= 1'b0;  // transfer finished
      if (div_wr)
        divider_o <= wdata_i[`SPI_DIV_LEN-1:0];
    end
  end

  always_comb
  begin
    ctrl_rd = '0;
    ctrl_rd[`SPI_CHAR_LEN_BITS-1:0] = len_o;
    ctrl_rd[`SPI_CTRL_GO]    = go_o;
    ctrl_rd[`SPI_CTRL_RXNEG] = rx_negedge_o;
    ctrl_rd[`SPI_CTRL_TXNEG] = tx_negedge_o;
    ctrl_rd[`SPI_CTRL_LSB]   = lsb_o;
    ctrl_rd[`SPI_CTRL_IE]    = ie_o;
  end

  // read data is registered, valid the cycle after rd_i
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      rdata_o <= '0;
    else if (rd_i)
    begin
      case (addr_i)
        `SPI_ADDR_DATA: rdata_o <= rx_word_i.word;
        `SPI_ADDR_CTRL: rdata_o <= ctrl_rd;
        `SPI_ADDR_DIV:  rdata_o <= {{(32-`SPI_DIV_LEN){1'b0}}, divider_o};
        default:        rdata_o <= {29'b0, tip_i, irq_i, done_i};
      endcase
    end
  end

  a_latch_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    latch_o |=> !latch_o);

  a_go_idle_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(go_o) |-> !tip_i);

endmodule

//--- hw/spi_clock_gen.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_clock_gen (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic [`SPI_DIV_LEN-1:0] divider_i,
  output logic                    sclk_o,
  output logic                    pos_edge_o,
  output logic                    neg_edge_o
);

  logic [`SPI_DIV_LEN-1:0] cnt_q;
  logic                    sclk_q;
  logic                    toggle;  // sclk flips on the next clock

  // first toggle comes in the first enabled cycle, then every divider+1
  assign toggle     = enable_i && (cnt_q == divider_i);
  assign pos_edge_o = toggle && !sclk_q;
  assign neg_edge_o = toggle && sclk_q;

  // hides the rise that coincides with the end of a transfer
  assign sclk_o = sclk_q && enable_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cnt_q  <= '0;
      sclk_q <= 1'b0;
    end
    else if (!enable_i)
    begin
      cnt_q  <= divider_i;  // idle, ready for the next start
      sclk_q <= 1'b0;
    end
    else
    begin
      if (cnt_q == '0)
        cnt_q <= divider_i;
      else
        cnt_q <= cnt_q - 1'b1;
      if (toggle)
        sclk_q <= ~sclk_q;
    end
  end

  // the idle reload must leave the first enabled cycle on a rising edge
  a_start_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(enable_i) |-> pos_edge_o);

endmodule

//--- hw/spi_shift.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_shift (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          latch_i,
  input  logic [3:0]                    byte_sel_i,
  input  spi_pkg::spi_word_u            tx_word_i,
  input  logic [`SPI_CHAR_LEN_BITS-1:0] len_i,
  input  logic                          lsb_i,
  input  logic                          go_i,
  input  logic                          pos_edge_i,
  input  logic                          neg_edge_i,
  input  logic                          rx_negedge_i,
  input  logic                          tx_negedge_i,
  input  logic                          sclk_i,
  input  logic                          miso_i,
  output logic                          tip_o,
  output logic                          last_o,
  output logic [`SPI_MAX_CHAR-1:0]      rx_word_o,
  output logic                          mosi_o
);

  import spi_pkg::*;

  localparam int unsigned CW = `SPI_CHAR_LEN_BITS + 1;  // counter holds 32

  logic [CW-1:0]            cnt_q;    // bits left in the character
  logic [CW-1:0]            n_bits;   // decoded character length
  logic [CW-1:0]            cnt_eff;
  logic [CW-1:0]            tx_pos;
  logic [CW-1:0]            rx_pos;
  logic                     tx_clk;
  logic                     rx_clk;
  spi_word_u                tx_q;
  logic [`SPI_MAX_CHAR-1:0] rx_q;

  assign n_bits  = {~|len_i, len_i};
  // while idle look at the freshly written length, not the old count
  assign cnt_eff = tip_o ? cnt_q : n_bits;
  assign last_o  = ~|cnt_q;

  assign tx_pos = lsb_i ? n_bits - cnt_eff : cnt_eff - CW'(1);
  // on a falling-edge sample the count has already moved on
  assign rx_pos = rx_negedge_i ? (lsb_i ? n_bits - cnt_q - CW'(1) : cnt_q)
                               : (lsb_i ? n_bits - cnt_q : cnt_q - CW'(1));

  assign tx_clk = (tx_negedge_i ? neg_edge_i : pos_edge_i) && !last_o;
  assign rx_clk = rx_negedge_i ? (neg_edge_i && sclk_i) : (pos_edge_i && !last_o);

  assign rx_word_o = rx_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cnt_q <= '0;
    else if (!tip_o)
      cnt_q <= n_bits;
    else if (pos_edge_i && !last_o)
      cnt_q <= cnt_q - CW'(1);  // one bit per rising sclk
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      tip_o <= 1'b0;
    else if (go_i && !tip_o)
      tip_o <= 1'b1;
    else if (tip_o && last_o && pos_edge_i)
      tip_o <= 1'b0;
  end

  // byte lanes merge only between transfers
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      tx_q <= '0;
    else if (latch_i && !tip_o)
    begin
      for (int i = 0; i < 4; i++)
      begin
        if (byte_sel_i[i])
          tx_q.bytes[i] <= tx_word_i.bytes[i];
      end
    end
  end

  // idle keeps the first bit on the line ahead of the first edge
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      mosi_o <= 1'b0;
    else if (tx_clk || !tip_o)
      mosi_o <= tx_q.word[tx_pos[CW-2:0]];
  end

  always_ff @(posedge clk_i)
  begin
    if (go_i && !tip_o)
      rx_q <= '0;  // upper bits stay zero for short characters
    else if (tip_o && rx_clk)
      rx_q[rx_pos[CW-2:0]] <= miso_i;
  end

  a_tip_end: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $fell(tip_o) |-> $past(pos_edge_i && last_o));

endmodule

//--- hw/spi_rx_status.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_rx_status (
  input  logic                     clk_i,
  input  logic                     rst_ni,
  input  logic                     tip_i,
  input  logic [`SPI_MAX_CHAR-1:0] rx_word_i,
  input  logic                     ie_i,
  input  logic                     stat_rd_i,
  output spi_pkg::spi_word_u       rx_data_o,
  output logic                     done_o,
  output logic                     irq_o
);

  import spi_pkg::*;

  logic      tip_q;
  logic      xfer_end;  // first idle cycle after a transfer
  spi_word_u rx_q;

  assign xfer_end  = tip_q && !tip_i;
  assign rx_data_o = rx_q;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      tip_q  <= 1'b0;
      done_o <= 1'b0;
      irq_o  <= 1'b0;
    end
    else
    begin
      tip_q <= tip_i;
      if (xfer_end)
      begin
        done_o <= 1'b1;
        irq_o  <= ie_i;
      end
      else if (stat_rd_i)
      begin
        done_o <= 1'b0;  // read clears both
        irq_o  <= 1'b0;
      end
    end
  end

  // held here so the next transfer does not disturb the readable word
  always_ff @(posedge clk_i)
  begin
    if (xfer_end)
      rx_q.word <= rx_word_i;
  end

  a_irq_done: assert property (@(posedge clk_i) disable iff (!rst_ni)
    irq_o |-> done_o);

endmodule

//--- hw/spi_master_top.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master_top (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        wr_i,
  input  logic        rd_i,
  input  logic [1:0]  addr_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  be_i,
  output logic [31:0] rdata_o,
  output logic        sclk_o,
  output logic        mosi_o,
  input  logic        miso_i,
  output logic        irq_o
);

  import spi_pkg::*;

  logic                          latch;
  logic [3:0]                    byte_sel;
  spi_word_u                     tx_word;
  spi_word_u                     rx_data;   // captured word for reads
  logic [`SPI_MAX_CHAR-1:0]      rx_shift;  // live shift register
  logic [`SPI_CHAR_LEN_BITS-1:0] len;
  logic [`SPI_DIV_LEN-1:0]       divider;
  logic                          lsb;
  logic                          go;
  logic                          rx_negedge;
  logic                          tx_negedge;
  logic                          ie;
  logic                          stat_rd;
  logic                          tip;
  logic                          done;
  logic                          pos_edge;
  logic                          neg_edge;

  spi_reg_decode i_spi_reg_decode (
    .clk_i, .rst_ni, .wr_i, .rd_i, .addr_i, .wdata_i, .be_i,
    .tip_i        (tip),
    .rx_word_i    (rx_data),
    .done_i       (done),
    .irq_i        (irq_o),
    .rdata_o,
    .latch_o      (latch),
    .byte_sel_o   (byte_sel),
    .tx_word_o    (tx_word),
    .len_o        (len),
    .lsb_o        (lsb),
    .go_o         (go),
    .rx_negedge_o (rx_negedge),
    .tx_negedge_o (tx_negedge),
    .ie_o         (ie),
    .divider_o    (divider),
    .stat_rd_o    (stat_rd)
  );

  spi_clock_gen i_spi_clock_gen (
    .clk_i, .rst_ni,
    .enable_i   (tip),  // serial clock runs only during a transfer
    .divider_i  (divider),
    .sclk_o,
    .pos_edge_o (pos_edge),
    .neg_edge_o (neg_edge)
  );

  spi_shift i_spi_shift (
    .clk_i, .rst_ni,
    .latch_i      (latch),
    .byte_sel_i   (byte_sel),
    .tx_word_i    (tx_word),
    .len_i        (len),
    .lsb_i        (lsb),
    .go_i         (go),
    .pos_edge_i   (pos_edge),
    .neg_edge_i   (neg_edge),
    .rx_negedge_i (rx_negedge),
    .tx_negedge_i (tx_negedge),
    .sclk_i       (sclk_o),
    .miso_i,
    .tip_o        (tip),
    .last_o       (),
    .rx_word_o    (rx_shift),
    .mosi_o
  );

  spi_rx_status i_spi_rx_status (
    .clk_i, .rst_ni,
    .tip_i     (tip),
    .rx_word_i (rx_shift),
    .ie_i      (ie),
    .stat_rd_i (stat_rd),
    .rx_data_o (rx_data),
    .done_o    (done),
    .irq_o
  );

endmodule

//--- dv/spi_master_tb.sv
`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_master_tb;

  localparam int CLK_PERIOD   = 100;
  localparam int NUM_RAND     = 8;
  localparam int NUM_XFER     = NUM_RAND + 5;
  localparam int XFER_MAX_CYC = `SPI_MAX_CHAR * 2 * 8 + 40;  // divider up to 7, plus bus traffic
  localparam int WATCHDOG_NS  = 2 * (NUM_XFER * XFER_MAX_CYC + 20) * CLK_PERIOD;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        wr_i;
  logic        rd_i;
  logic [1:0]  addr_i;
  logic [31:0] wdata_i;
  logic [3:0]  be_i;
  logic [31:0] rdata_o;
  logic        sclk_o;
  logic        mosi_o;
  logic        irq_o;

  logic [31:0] lcg_state = 32'd20;
  int          mismatch_cnt = 0;
  int          other_cnt = 0;

  logic        chk_en = 1'b0;  // one-cycle compare strobe
  logic [31:0] chk_got;
  logic [31:0] chk_exp;
  string       chk_what;
  logic        xfer_on = 1'b0;  // from go write until done is seen
  logic        irq_quiet = 1'b0;
  int unsigned cur_div = 0;
  logic        sclk_d = 1'b0;
  logic        seen_rise = 1'b0;
  logic        gap_chk = 1'b0;
  int unsigned gap_cnt = 0;
  int unsigned gap_len = 0;

  spi_master_top i_spi_master_top (
    .clk_i, .rst_ni, .wr_i, .rd_i, .addr_i, .wdata_i, .be_i, .rdata_o,
    .sclk_o, .mosi_o,
    .miso_i (mosi_o),  // loopback
    .irq_o
  );

  always #(CLK_PERIOD/2) clk_i = ~clk_i;

  // cycles between sclk rises within one transfer
  always @(posedge clk_i)
  begin
    sclk_d  <= sclk_o;
    gap_chk <= 1'b0;
    if (!xfer_on)
      seen_rise <= 1'b0;
    else if (sclk_o && !sclk_d)
    begin
      gap_chk   <= seen_rise;  // no spacing for the first rise
      gap_len   <= gap_cnt;
      gap_cnt   <= 1;
      seen_rise <= 1'b1;
    end
    else
      gap_cnt <= gap_cnt + 1;
  end

  a_value: assert property (@(posedge clk_i) chk_en |-> chk_got == chk_exp)
    else
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: %s got %h expected %h", $time, chk_what,
               $sampled(chk_got), $sampled(chk_exp));
    end

  a_sclk_gap: assert property (@(posedge clk_i) gap_chk |-> gap_len == 2 * (cur_div + 1))
    else
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: sclk rise spacing %0d expected %0d", $time,
               $sampled(gap_len), 2 * ($sampled(cur_div) + 1));
    end

  a_sclk_idle: assert property (@(posedge clk_i) !xfer_on |-> !sclk_o)
    else
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: sclk high outside a transfer", $time);
    end

  a_reset_idle: assert property (@(posedge clk_i)
    $rose(rst_ni) |-> (!sclk_o && !mosi_o && !irq_o))
    else
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: serial or irq output high after reset", $time);
    end

  a_irq_quiet: assert property (@(posedge clk_i) irq_quiet |-> !irq_o)
    else
    begin
      mismatch_cnt++;
      $display("mismatch at %0t: irq high with interrupt enable off", $time);
    end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    @(posedge clk_i);
    chk_got  <= got;
    chk_exp  <= exp;
    chk_what <= what;
    chk_en   <= 1'b1;
    @(posedge clk_i);
    chk_en <= 1'b0;
  endtask

  task automatic bus_write(input logic [1:0] addr, input logic [31:0] data, input logic [3:0] be);
    @(posedge clk_i);
    wr_i    <= 1'b1;
    addr_i  <= addr;
    wdata_i <= data;
    be_i    <= be;
    @(posedge clk_i);
    wr_i <= 1'b0;
  endtask

  task automatic bus_read(input logic [1:0] addr, output logic [31:0] data);
    @(posedge clk_i);
    rd_i   <= 1'b1;
    addr_i <= addr;
    @(posedge clk_i);
    rd_i <= 1'b0;
    @(posedge clk_i);
    data = rdata_o;  // registered the edge before
  endtask

  task automatic wait_done(output logic [31:0] stat);
    int polls;
    polls = 0;
    stat  = '0;
    while (!stat[`SPI_STAT_DONE] && polls < XFER_MAX_CYC)
    begin
      bus_read(`SPI_ADDR_STAT, stat);
      polls++;
    end
    if (!stat[`SPI_STAT_DONE])
    begin
      other_cnt++;
      $display("done flag never set, the transfer did not finish");
    end
  endtask

  // tx word must already sit in the data register
  task automatic run_xfer(input logic [31:0] sent, input logic [4:0] len, input int unsigned div,
                          input logic lsb, input logic txneg, input logic rxneg, input logic ie,
                          input logic mid_wr);
    logic [31:0] ctrl;
    logic [31:0] rd;
    logic [31:0] mask;
    mask = (len == 5'd0) ? 32'hffff_ffff : (32'h1 << len) - 32'h1;
    ctrl = '0;
    ctrl[`SPI_CHAR_LEN_BITS-1:0] = len;
    ctrl[`SPI_CTRL_GO]    = 1'b1;
    ctrl[`SPI_CTRL_RXNEG] = rxneg;
    ctrl[`SPI_CTRL_TXNEG] = txneg;
    ctrl[`SPI_CTRL_LSB]   = lsb;
    ctrl[`SPI_CTRL_IE]    = ie;
    bus_write(`SPI_ADDR_DIV, div, 4'hf);
    cur_div   <= div;
    irq_quiet <= !ie;
    xfer_on   <= 1'b1;
    bus_write(`SPI_ADDR_CTRL, ctrl, 4'hf);
    if (mid_wr)
      bus_write(`SPI_ADDR_DATA, ~sent, 4'hf);  // dropped while busy
    bus_read(`SPI_ADDR_CTRL, rd);
    check_value({31'b0, rd[`SPI_CTRL_GO]}, 32'h1, "go bit during transfer");
    wait_done(rd);
    xfer_on <= 1'b0;
    check_value(rd, {30'b0, ie, 1'b1}, "status after transfer");
    check_value({31'b0, irq_o}, 32'h0, "irq after status read");
    bus_read(`SPI_ADDR_DATA, rd);
    check_value(rd, sent & mask, "received word");
  endtask

  initial
  begin
    #(WATCHDOG_NS);
    other_cnt++;
    $display("watchdog expired after %0d ns, the run was stopped", WATCHDOG_NS);
    $display("Done: errors found");
    $finish;
  end

  initial
  begin
    logic [31:0] rd;
    logic [31:0] word_a;
    logic [31:0] word_b;
    logic [31:0] merged;
    int          lane;
    logic        txneg;
    rst_ni  = 1'b0;
    wr_i    = 1'b0;
    rd_i    = 1'b0;
    addr_i  = '0;
    wdata_i = '0;
    be_i    = '0;
    repeat (8) @(posedge clk_i);
    rst_ni <= 1'b1;

    bus_read(`SPI_ADDR_STAT, rd);
    check_value(rd, 32'h0, "status after reset");

    // full 32-bit character, msb first
    word_a = lcg_next();
    bus_write(`SPI_ADDR_DATA, word_a, 4'hf);
    run_xfer(word_a, 5'd0, lcg_next() >> 29, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0);

    for (int i = 0; i < NUM_RAND; i++)
    begin
      word_a = lcg_next();
      txneg  = lcg_next() >= 32'h8000_0000;
      bus_write(`SPI_ADDR_DATA, word_a, 4'hf);
      run_xfer(word_a, 5'(lcg_next() >> 27), lcg_next() >> 29, (i % 2) == 1, txneg, !txneg,
               1'b0, 1'b0);
    end

    // byte lane merge, then a write during the transfer
    word_a = lcg_next();
    word_b = lcg_next();
    lane   = int'(lcg_next() >> 30);
    merged = word_a;
    merged[lane*8 +: 8] = word_b[lane*8 +: 8];
    bus_write(`SPI_ADDR_DATA, word_a, 4'hf);
    bus_write(`SPI_ADDR_DATA, word_b, 4'(1 << lane));
    run_xfer(merged, 5'd0, lcg_next() >> 29, 1'b0, 1'b1, 1'b0, 1'b0, 1'b1);
    run_xfer(merged, 5'd0, lcg_next() >> 29, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);

    // interrupt enable on, then off
    run_xfer(merged, 5'd12, lcg_next() >> 29, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
    run_xfer(merged, 5'd20, lcg_next() >> 29, 1'b1, 1'b0, 1'b1, 1'b0, 1'b0);

    @(posedge clk_i);
    $display("errors: %0d value mismatches, %0d other failures", mismatch_cnt, other_cnt);
    if (mismatch_cnt == 0 && other_cnt == 0)
      $display("Done: no errors");
    else
      $display("Done: errors found");
    $finish;
  end

endmodule

//--- spi_master.f
+incdir+include
hw/spi_pkg.sv
hw/spi_reg_decode.sv
hw/spi_clock_gen.sv
hw/spi_shift.sv
hw/spi_rx_status.sv
hw/spi_master_top.sv
dv/spi_master_tb.sv

//--- Makefile
# Verilator build and run of the SPI master testbench

VERILATOR ?= verilator
TOP       ?= spi_master_tb
FILELIST  ?= spi_master.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  ?= Done: errors found
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "simulation FAILED"; exit 1; \
	elif ! grep -q "^Done: no" $(LOG); then \
	  echo "simulation ended without a result line"; exit 1; \
	else \
	  echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
